/* Bender.yml */
package:
  name: exec_cluster

sources:
  - include_dirs:
      - src
    files:
      - src/exec_pkg.sv
      - src/cond_eval.sv
      - src/reg_file.sv
      - src/issue_queue.sv
      - src/split_alu.sv
      - src/exec_cluster.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_exec_cluster.sv

/* sources.f */
+incdir+src
src/exec_pkg.sv
src/cond_eval.sv
src/reg_file.sv
src/issue_queue.sv
src/split_alu.sv
src/exec_cluster.sv
testbench/tb_exec_cluster.sv

/* src/cond_eval.sv */
`timescale 1ns/1ps

module cond_eval
  import exec_pkg::*;
(
  input  cond_t  cond,
  input  flags_t flags,
  output logic   taken
);

  logic n_eq_v;

  assign n_eq_v = (flags.negative == flags.overflow);

  always_comb begin
    case (cond)
      eq: taken = flags.zero;
      ne: taken = ~flags.zero;
      cs: taken = flags.carry;
      cc: taken = ~flags.carry;
      mi: taken = flags.negative;
      pl: taken = ~flags.negative;
      vs: taken = flags.overflow;
      vc: taken = ~flags.overflow;
      // unsigned compares, carry means no borrow
      hi: taken = flags.carry & ~flags.zero;
      ls: taken = ~flags.carry | flags.zero;
      // signed compares
      ge: taken = n_eq_v;
      lt: taken = ~n_eq_v;
      gt: taken = n_eq_v & ~flags.zero;
      le: taken = ~n_eq_v | flags.zero;
      al: taken = 1'b1;
      nv: taken = 1'b0;
    endcase
  end

endmodule

/* src/exec_cluster.sv */
`timescale 1ns/1ps

module exec_cluster
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  output logic    in_ready,
  input  alu_op_t in_op,
  input  cond_t   in_cond,
  input  tag_t    in_src_a,
  input  tag_t    in_src_b,
  input  tag_t    in_src_fl,
  input  tag_t    in_dst,
  input  data_t   in_imm,
  input  logic    in_use_imm,
  output logic    wb_valid,
  output tag_t    wb_tag,
  output data_t   wb_data,
  output flags_t  wb_flags
);

  logic    alloc_valid;
  tag_t    alloc_tag;
  logic    src_a_busy;
  logic    src_b_busy;
  logic    src_fl_busy;
  logic    iss_valid;
  alu_op_t iss_op;
  cond_t   iss_cond;
  tag_t    iss_src_a;
  tag_t    iss_src_b;
  tag_t    iss_src_fl;
  tag_t    iss_dst;
  data_t   iss_imm;
  logic    iss_use_imm;
  data_t   rd_a;
  data_t   rd_b;
  flags_t  rd_fl;

  issue_queue u_iq (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_op       (in_op),
    .in_cond     (in_cond),
    .in_src_a    (in_src_a),
    .in_src_b    (in_src_b),
    .in_src_fl   (in_src_fl),
    .in_dst      (in_dst),
    .in_imm      (in_imm),
    .in_use_imm  (in_use_imm),
    .src_a_busy  (src_a_busy),
    .src_b_busy  (src_b_busy),
    .src_fl_busy (src_fl_busy),
    .alloc_valid (alloc_valid),
    .alloc_tag   (alloc_tag),
    .wb_valid    (wb_valid),
    .wb_tag      (wb_tag),
    .iss_valid   (iss_valid),
    .iss_op      (iss_op),
    .iss_cond    (iss_cond),
    .iss_src_a   (iss_src_a),
    .iss_src_b   (iss_src_b),
    .iss_src_fl  (iss_src_fl),
    .iss_dst     (iss_dst),
    .iss_imm     (iss_imm),
    .iss_use_imm (iss_use_imm)
  );

  // scoreboard lookup uses the incoming op's sources
  reg_file u_rf (
    .clk         (clk),
    .rst         (rst),
    .alloc_valid (alloc_valid),
    .alloc_tag   (alloc_tag),
    .src_a       (in_src_a),
    .src_b       (in_src_b),
    .src_fl      (in_src_fl),
    .src_a_busy  (src_a_busy),
    .src_b_busy  (src_b_busy),
    .src_fl_busy (src_fl_busy),
    .rd_tag_a    (iss_src_a),
    .rd_tag_b    (iss_src_b),
    .rd_tag_fl   (iss_src_fl),
    .rd_a        (rd_a),
    .rd_b        (rd_b),
    .rd_fl       (rd_fl),
    .wb_valid    (wb_valid),
    .wb_tag      (wb_tag),
    .wb_data     (wb_data),
    .wb_flags    (wb_flags)
  );

  split_alu u_alu (
    .clk         (clk),
    .rst         (rst),
    .iss_valid   (iss_valid),
    .iss_op      (iss_op),
    .iss_cond    (iss_cond),
    .iss_dst     (iss_dst),
    .iss_imm     (iss_imm),
    .iss_use_imm (iss_use_imm),
    .rd_a        (rd_a),
    .rd_b        (rd_b),
    .rd_fl       (rd_fl),
    .wb_valid    (wb_valid),
    .wb_tag      (wb_tag),
    .wb_data     (wb_data),
    .wb_flags    (wb_flags)
  );

endmodule

/* src/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// register data width, split into two ALU halves
`define EXEC_DATA_W 64
`define EXEC_HALF_W 32

// physical register file
`define EXEC_NUM_TAGS 32
`define EXEC_TAG_W 5

// issue queue slots
`define EXEC_IQ_DEPTH 8

`endif

/* src/exec_pkg.sv */
`include "exec_config.svh"

package exec_pkg;

  typedef logic [`EXEC_TAG_W-1:0] tag_t;
  typedef logic [`EXEC_DATA_W-1:0] data_t;
  typedef logic [`EXEC_HALF_W-1:0] half_t;

  // condition flags, carry in the top bit
  typedef struct packed {
    logic carry;
    logic overflow;
    logic negative;
    logic zero;
  } flags_t;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mov
  } alu_op_t;

  // condition codes, odd code is the inverse of the even one below it
  typedef enum logic [3:0] {
    eq,
    ne,
    cs,
    cc,
    mi,
    pl,
    vs,
    vc,
    hi,
    ls,
    ge,
    lt,
    gt,
    le,
    al,
    nv
  } cond_t;

endpackage

/* src/issue_queue.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module issue_queue
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  output logic    in_ready,
  input  alu_op_t in_op,
  input  cond_t   in_cond,
  input  tag_t    in_src_a,
  input  tag_t    in_src_b,
  input  tag_t    in_src_fl,
  input  tag_t    in_dst,
  input  data_t   in_imm,
  input  logic    in_use_imm,
  input  logic    src_a_busy,
  input  logic    src_b_busy,
  input  logic    src_fl_busy,
  output logic    alloc_valid,
  output tag_t    alloc_tag,
  input  logic    wb_valid,
  input  tag_t    wb_tag,
  output logic    iss_valid,
  output alu_op_t iss_op,
  output cond_t   iss_cond,
  output tag_t    iss_src_a,
  output tag_t    iss_src_b,
  output tag_t    iss_src_fl,
  output tag_t    iss_dst,
  output data_t   iss_imm,
  output logic    iss_use_imm
);

  localparam int DEPTH = `EXEC_IQ_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  logic [DEPTH-1:0] slot_valid;
  logic [DEPTH-1:0] rdy_a;
  logic [DEPTH-1:0] rdy_b;
  logic [DEPTH-1:0] rdy_fl;
  alu_op_t          slot_op     [DEPTH];
  cond_t            slot_cond   [DEPTH];
  tag_t             slot_src_a  [DEPTH];
  tag_t             slot_src_b  [DEPTH];
  tag_t             slot_src_fl [DEPTH];
  tag_t             slot_dst    [DEPTH];
  data_t            slot_imm    [DEPTH];
  logic [DEPTH-1:0] slot_use_imm;

  logic [DEPTH-1:0] wake_a;
  logic [DEPTH-1:0] wake_b;
  logic [DEPTH-1:0] wake_fl;
  logic [DEPTH-1:0] can_issue;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] pick_idx;
  logic             free_found;
  logic             pick_found;
  logic             insert;

  assign in_ready    = free_found;
  assign insert      = in_valid & in_ready;
  assign alloc_valid = insert;
  assign alloc_tag   = in_dst;

  // result tag wakeup, seen by select in the writeback cycle
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      wake_a[i]    = wb_valid && (wb_tag == slot_src_a[i]);
      wake_b[i]    = wb_valid && (wb_tag == slot_src_b[i]);
      wake_fl[i]   = wb_valid && (wb_tag == slot_src_fl[i]);
      can_issue[i] = slot_valid[i] & (rdy_a[i] | wake_a[i]) & (rdy_b[i] | wake_b[i])
                     & (rdy_fl[i] | wake_fl[i]);
    end
  end

  // find first set, scanning down so the lowest index wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
      if (can_issue[i]) begin
        pick_found = 1'b1;
        pick_idx   = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= '0;
      rdy_a      <= '0;
      rdy_b      <= '0;
      rdy_fl     <= '0;
      iss_valid  <= 1'b0;
    end else begin
      rdy_a  <= rdy_a | wake_a;
      rdy_b  <= rdy_b | wake_b;
      rdy_fl <= rdy_fl | wake_fl;
      if (pick_found) begin
        slot_valid[pick_idx] <= 1'b0;
      end
      if (insert) begin
        slot_valid[free_idx] <= 1'b1;
        rdy_a[free_idx]      <= ~src_a_busy;
        rdy_b[free_idx]      <= ~src_b_busy;
        rdy_fl[free_idx]     <= ~src_fl_busy;
      end
      iss_valid <= pick_found;
    end
  end

  always_ff @(posedge clk) begin
    if (insert) begin
      slot_op[free_idx]      <= in_op;
      slot_cond[free_idx]    <= in_cond;
      slot_src_a[free_idx]   <= in_src_a;
      slot_src_b[free_idx]   <= in_src_b;
      slot_src_fl[free_idx]  <= in_src_fl;
      slot_dst[free_idx]     <= in_dst;
      slot_imm[free_idx]     <= in_imm;
      slot_use_imm[free_idx] <= in_use_imm;
    end
    if (pick_found) begin
      iss_op      <= slot_op[pick_idx];
      iss_cond    <= slot_cond[pick_idx];
      iss_src_a   <= slot_src_a[pick_idx];
      iss_src_b   <= slot_src_b[pick_idx];
      iss_src_fl  <= slot_src_fl[pick_idx];
      iss_dst     <= slot_dst[pick_idx];
      iss_imm     <= slot_imm[pick_idx];
      iss_use_imm <= slot_use_imm[pick_idx];
    end
  end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module reg_file
  import exec_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   alloc_valid,
  input  tag_t   alloc_tag,
  input  tag_t   src_a,
  input  tag_t   src_b,
  input  tag_t   src_fl,
  output logic   src_a_busy,
  output logic   src_b_busy,
  output logic   src_fl_busy,
  input  tag_t   rd_tag_a,
  input  tag_t   rd_tag_b,
  input  tag_t   rd_tag_fl,
  output data_t  rd_a,
  output data_t  rd_b,
  output flags_t rd_fl,
  input  logic   wb_valid,
  input  tag_t   wb_tag,
  input  data_t  wb_data,
  input  flags_t wb_flags
);

  localparam int NUM_TAGS = `EXEC_NUM_TAGS;

  data_t               data_q  [NUM_TAGS];
  flags_t              flags_q [NUM_TAGS];
  logic [NUM_TAGS-1:0] busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
      for (int i = 0; i < NUM_TAGS; i++) begin
        data_q[i]  <= '0;
        flags_q[i] <= '0;
      end
    end else begin
      if (wb_valid) begin
        data_q[wb_tag]  <= wb_data;
        flags_q[wb_tag] <= wb_flags;
        busy_q[wb_tag]  <= 1'b0;
      end
      // a new producer claims its tag
      if (alloc_valid) begin
        busy_q[alloc_tag] <= 1'b1;
      end
    end
  end

  // writeback in flight counts as done
  assign src_a_busy  = busy_q[src_a] & ~(wb_valid && (wb_tag == src_a));
  assign src_b_busy  = busy_q[src_b] & ~(wb_valid && (wb_tag == src_b));
  assign src_fl_busy = busy_q[src_fl] & ~(wb_valid && (wb_tag == src_fl));

  assign rd_a  = data_q[rd_tag_a];
  assign rd_b  = data_q[rd_tag_b];
  assign rd_fl = flags_q[rd_tag_fl];

endmodule

/* src/split_alu.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module split_alu
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    iss_valid,
  input  alu_op_t iss_op,
  input  cond_t   iss_cond,
  input  tag_t    iss_dst,
  input  data_t   iss_imm,
  input  logic    iss_use_imm,
  input  data_t   rd_a,
  input  data_t   rd_b,
  input  flags_t  rd_fl,
  output logic    wb_valid,
  output tag_t    wb_tag,
  output data_t   wb_data,
  output flags_t  wb_flags
);

  localparam int HW  = `EXEC_HALF_W;
  localparam int MSB = `EXEC_DATA_W - 1;

  data_t       opnd_b;
  logic [HW:0] sum_lo;
  half_t       res_lo;
  logic        taken;

  logic        s1_valid;
  alu_op_t     s1_op;
  tag_t        s1_dst;
  data_t       s1_a;
  data_t       s1_b;
  half_t       s1_lo;
  logic        s1_carry;
  logic        s1_taken;
  flags_t      s1_fl;

  logic [HW:0] sum_hi;
  half_t       res_hi;
  data_t       result;
  flags_t      flags_new;
  logic        arith;

  cond_eval u_cond (
    .cond  (iss_cond),
    .flags (rd_fl),
    .taken (taken)
  );

  // stage one, low half
  always_comb begin
    opnd_b = iss_use_imm ? iss_imm : rd_b;
    // sub is a + ~b + 1
    if (iss_op == op_sub) begin
      opnd_b = ~opnd_b;
    end
    sum_lo = {1'b0, rd_a[HW-1:0]} + {1'b0, opnd_b[HW-1:0]} + (HW + 1)'(iss_op == op_sub);
    case (iss_op)
      op_add, op_sub: res_lo = sum_lo[HW-1:0];
      op_and:         res_lo = rd_a[HW-1:0] & opnd_b[HW-1:0];
      op_or:          res_lo = rd_a[HW-1:0] | opnd_b[HW-1:0];
      op_xor:         res_lo = rd_a[HW-1:0] ^ opnd_b[HW-1:0];
      op_mov:         res_lo = opnd_b[HW-1:0];
      default:        res_lo = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op    <= iss_op;
    s1_dst   <= iss_dst;
    s1_a     <= rd_a;
    s1_b     <= opnd_b;
    s1_lo    <= res_lo;
    s1_carry <= sum_lo[HW];
    s1_taken <= taken;
    s1_fl    <= rd_fl;
  end

  // stage two, high half on the carry out of the low half
  always_comb begin
    sum_hi = {1'b0, s1_a[MSB:HW]} + {1'b0, s1_b[MSB:HW]} + (HW + 1)'(s1_carry);
    case (s1_op)
      op_add, op_sub: res_hi = sum_hi[HW-1:0];
      op_and:         res_hi = s1_a[MSB:HW] & s1_b[MSB:HW];
      op_or:          res_hi = s1_a[MSB:HW] | s1_b[MSB:HW];
      op_xor:         res_hi = s1_a[MSB:HW] ^ s1_b[MSB:HW];
      op_mov:         res_hi = s1_b[MSB:HW];
      default:        res_hi = '0;
    endcase
    result             = {res_hi, s1_lo};
    arith              = (s1_op == op_add) || (s1_op == op_sub);
    flags_new.carry    = arith & sum_hi[HW];
    // b is already inverted for sub
    flags_new.overflow = arith & (s1_a[MSB] == s1_b[MSB]) & (result[MSB] != s1_a[MSB]);
    flags_new.negative = result[MSB];
    flags_new.zero     = (result == '0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= s1_valid;
    end
  end

  // condition false keeps a and the old flags
  always_ff @(posedge clk) begin
    wb_tag   <= s1_dst;
    wb_data  <= s1_taken ? result : s1_a;
    wb_flags <= s1_taken ? flags_new : s1_fl;
  end

endmodule

/* testbench/tb_exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec_cluster;
  import exec_pkg::*;

  localparam int NUM_TAGS   = `EXEC_NUM_TAGS;
  localparam int WAIT_LIMIT = 400;

  typedef struct packed {
    data_t  data;
    flags_t flags;
  } ref_t;

  logic    clk;
  logic    rst;
  logic    in_valid;
  logic    in_ready;
  alu_op_t in_op;
  cond_t   in_cond;
  tag_t    in_src_a;
  tag_t    in_src_b;
  tag_t    in_src_fl;
  tag_t    in_dst;
  data_t   in_imm;
  logic    in_use_imm;
  logic    wb_valid;
  tag_t    wb_tag;
  data_t   wb_data;
  flags_t  wb_flags;

  // program-order model and expected results per tag
  data_t  shadow_data  [NUM_TAGS];
  flags_t shadow_flags [NUM_TAGS];
  data_t  exp_data     [NUM_TAGS];
  flags_t exp_flags    [NUM_TAGS];
  data_t  last_data    [NUM_TAGS];
  logic   pending      [NUM_TAGS];
  logic   written      [NUM_TAGS];
  logic   dst_used     [NUM_TAGS];
  logic   read_used    [NUM_TAGS];
  int     pending_count;
  int     wb_count;
  int     stall_cycles;
  int     value_errors;
  int     other_errors;
  string  test_name;

  exec_cluster UUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_cond    (in_cond),
    .in_src_a   (in_src_a),
    .in_src_b   (in_src_b),
    .in_src_fl  (in_src_fl),
    .in_dst     (in_dst),
    .in_imm     (in_imm),
    .in_use_imm (in_use_imm),
    .wb_valid   (wb_valid),
    .wb_tag     (wb_tag),
    .wb_data    (wb_data),
    .wb_flags   (wb_flags)
  );

  always #4 clk = ~clk;

  function automatic logic cond_holds(cond_t c, flags_t f);
    case (c)
      eq:      return f.zero;
      ne:      return !f.zero;
      cs:      return f.carry;
      cc:      return !f.carry;
      mi:      return f.negative;
      pl:      return !f.negative;
      vs:      return f.overflow;
      vc:      return !f.overflow;
      hi:      return f.carry && !f.zero;
      ls:      return !(f.carry && !f.zero);
      ge:      return f.negative == f.overflow;
      lt:      return f.negative != f.overflow;
      gt:      return (f.negative == f.overflow) && !f.zero;
      le:      return !((f.negative == f.overflow) && !f.zero);
      al:      return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ref_t alu_ref(alu_op_t op, cond_t c, data_t a, data_t b, flags_t fl);
    ref_t        r;
    logic [64:0] wide;
    r.flags = '0;
    case (op)
      op_add: begin
        wide             = {1'b0, a} + {1'b0, b};
        r.data           = wide[63:0];
        r.flags.carry    = wide[64];
        r.flags.overflow = (a[63] == b[63]) && (r.data[63] != a[63]);
      end
      op_sub: begin
        // carry set means no borrow
        wide             = {1'b0, a} + {1'b0, ~b} + 65'd1;
        r.data           = wide[63:0];
        r.flags.carry    = wide[64];
        r.flags.overflow = (a[63] != b[63]) && (r.data[63] != a[63]);
      end
      op_and:  r.data = a & b;
      op_or:   r.data = a | b;
      op_xor:  r.data = a ^ b;
      default: r.data = b;
    endcase
    r.flags.negative = r.data[63];
    r.flags.zero     = (r.data == 64'd0);
    if (!cond_holds(c, fl)) begin
      r.data  = a;
      r.flags = fl;
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_other(input string what);
    other_errors++;
    $display("Error: %s", what);
  endtask

  task automatic print_counts();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
  endtask

  task automatic stop_on_timeout(input string what);
    report_other(what);
    print_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  // offer one op from a falling edge and model it once accepted
  task automatic issue_op(input alu_op_t op, input cond_t c, input int a, input int b,
                          input int fl, input int dst, input data_t imm, input logic use_imm);
    int    waited;
    data_t bval;
    ref_t  r;
    waited     = 0;
    in_valid   = 1'b1;
    in_op      = op;
    in_cond    = c;
    in_src_a   = tag_t'(a);
    in_src_b   = tag_t'(b);
    in_src_fl  = tag_t'(fl);
    in_dst     = tag_t'(dst);
    in_imm     = imm;
    in_use_imm = use_imm;
    while (!in_ready) begin
      if (waited == WAIT_LIMIT) begin
        stop_on_timeout("in_ready stayed low while an op was offered");
      end
      stall_cycles++;
      waited++;
      @(negedge clk);
    end
    bval              = use_imm ? imm : shadow_data[b];
    r                 = alu_ref(op, c, shadow_data[a], bval, shadow_flags[fl]);
    shadow_data[dst]  = r.data;
    shadow_flags[dst] = r.flags;
    exp_data[dst]     = r.data;
    exp_flags[dst]    = r.flags;
    pending[dst]      = 1'b1;
    pending_count++;
    written[dst]      = 1'b1;
    dst_used[dst]     = 1'b1;
    read_used[a]      = 1'b1;
    read_used[b]      = 1'b1;
    read_used[fl]     = 1'b1;
    @(negedge clk);
  endtask

  task automatic drain();
    int waited;
    waited   = 0;
    in_valid = 1'b0;
    while (pending_count != 0) begin
      if (waited == WAIT_LIMIT) begin
        stop_on_timeout("writebacks were still missing when the drain wait ran out");
      end
      waited++;
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    for (int t = 0; t < NUM_TAGS; t++) begin
      dst_used[t]  = 1'b0;
      read_used[t] = 1'b0;
    end
  endtask

  // each registered wb_valid pulse is seen once on the falling edge
  always @(negedge clk) begin
    if (!rst && wb_valid) begin
      wb_count++;
      last_data[wb_tag] = wb_data;
      if (!pending[wb_tag]) begin
        report_other($sformatf("writeback to tag %0d with no op outstanding", wb_tag));
      end else begin
        check_value($sformatf("%s tag %0d data", test_name, wb_tag), exp_data[wb_tag], wb_data);
        check_value($sformatf("%s tag %0d flags", test_name, wb_tag), exp_flags[wb_tag],
                    wb_flags);
        pending[wb_tag] = 1'b0;
        pending_count--;
      end
    end
  end

  initial begin
    int      seed_value;
    int      n_ops;
    int      a;
    int      b;
    int      fl;
    int      dst;
    int      wb_start;
    int      srcs[$];
    int      cands[$];
    alu_op_t op;
    cond_t   c;
    seed_value    = $urandom(32'he85b_0446);
    clk           = 1'b0;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_op         = op_add;
    in_cond       = al;
    in_src_a      = '0;
    in_src_b      = '0;
    in_src_fl     = '0;
    in_dst        = '0;
    in_imm        = '0;
    in_use_imm    = 1'b0;
    pending_count = 0;
    wb_count      = 0;
    stall_cycles  = 0;
    value_errors  = 0;
    other_errors  = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      shadow_data[t]  = '0;
      shadow_flags[t] = '0;
      last_data[t]    = '0;
      pending[t]      = 1'b0;
      written[t]      = (t == 0);
      dst_used[t]     = 1'b0;
      read_used[t]    = 1'b0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;

    test_name = "reset";
    repeat (10) begin
      check_value("reset wb_valid", 64'd0, wb_valid);
      check_value("reset in_ready", 64'd1, in_ready);
      @(negedge clk);
    end

    // low halves chosen to carry into the high half
    test_name = "arith";
    issue_op(op_mov, al, 0, 0, 0, 1, 64'h0000_0001_ffff_ffff, 1'b1);
    issue_op(op_mov, al, 0, 0, 0, 2, 64'h0000_0000_0000_0001, 1'b1);
    issue_op(op_mov, al, 0, 0, 0, 3, 64'h7fff_ffff_ffff_ffff, 1'b1);
    issue_op(op_mov, al, 0, 0, 0, 4, 64'hffff_ffff_ffff_ffff, 1'b1);
    issue_op(op_mov, al, 0, 0, 0, 11, 64'h8000_0000_0000_0000, 1'b1);
    drain();
    issue_op(op_add, al, 1, 2, 0, 5, '0, 1'b0);
    issue_op(op_add, al, 3, 2, 0, 6, '0, 1'b0);
    issue_op(op_add, al, 4, 2, 0, 7, '0, 1'b0);
    issue_op(op_sub, al, 2, 1, 0, 8, '0, 1'b0);
    issue_op(op_sub, al, 1, 1, 0, 9, '0, 1'b0);
    issue_op(op_sub, al, 11, 2, 0, 10, '0, 1'b0);
    drain();

    test_name = "cond";
    for (int f = 5; f <= 10; f++) begin
      for (int k = 0; k < 16; k++) begin
        issue_op(op_sub, cond_t'(k), 1, 2, f, 12 + k, '0, 1'b0);
      end
      drain();
    end

    test_name = "random";
    for (int batch = 0; batch < 20; batch++) begin
      n_ops = 1 + $urandom_range(29);
      for (int k = 0; k < n_ops; k++) begin
        srcs.delete();
        cands.delete();
        for (int t = 0; t < NUM_TAGS; t++) begin
          if (written[t]) begin
            srcs.push_back(t);
          end
        end
        a  = srcs[$urandom_range(srcs.size() - 1)];
        b  = srcs[$urandom_range(srcs.size() - 1)];
        fl = srcs[$urandom_range(srcs.size() - 1)];
        // no reuse of a tag that this batch already reads or writes
        for (int t = 1; t < NUM_TAGS; t++) begin
          if (!dst_used[t] && !read_used[t] && t != a && t != b && t != fl) begin
            cands.push_back(t);
          end
        end
        if (cands.size() == 0) begin
          break;
        end
        dst = cands[$urandom_range(cands.size() - 1)];
        op  = alu_op_t'($urandom_range(5));
        c   = ($urandom_range(1) == 1) ? al : cond_t'($urandom_range(15));
        issue_op(op, c, a, b, fl, dst, {$urandom, $urandom}, $urandom_range(1));
        if ($urandom_range(3) == 0) begin
          in_valid = 1'b0;
          @(negedge clk);
        end
      end
      drain();
    end

    test_name    = "chain";
    stall_cycles = 0;
    wb_start     = wb_count;
    // the head waits on a fresh producer, so the queue fills up
    issue_op(op_mov, al, 0, 0, 0, 19, {$urandom, $urandom}, 1'b1);
    for (int k = 0; k < 12; k++) begin
      op = (k % 3 == 0) ? op_add : ((k % 3 == 1) ? op_sub : op_xor);
      issue_op(op, al, 19 + k, 19 + k, 19 + k, 20 + k, {$urandom, $urandom}, 1'b1);
    end
    drain();
    if (stall_cycles == 0) begin
      report_other("in_ready never went low during the dependent chain");
    end
    check_value("chain writeback count", 64'd13, wb_count - wb_start);
    check_value("chain final value", shadow_data[31], last_data[31]);

    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
